//--- verilog/game_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Match length, FIFO depth and UART bit time for the match controller
// Included by the packages and by every module that sizes something from them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// Shots in one match, keeper and shooter turns together
`define GAME_ROUNDS_PER_MATCH 6

// Sync byte FIFO holds 2**N entries
`define GAME_FIFO_DEPTH_LOG2 3

// Clock cycles per UART bit
`define GAME_CLKS_PER_BIT 4

`endif

//--- verilog/game_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game state, game mode and score types
// Referenced with scoped names only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "game_config.svh"

package game_pkg;

    typedef enum logic [2:0] {
        START   = 3'd0,
        KEEPER  = 3'd1,
        SHOOTER = 3'd2,
        WINNER  = 3'd3,
        LOSER   = 3'd4
    } g_state;

    typedef enum logic {
        MULTI = 1'b0,
        SOLO  = 1'b1
    } g_mode;

    // Holds scores and the round count up to a full match
    typedef logic [$clog2(`GAME_ROUNDS_PER_MATCH + 1) - 1:0] score_t;

endpackage

//--- verilog/link_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types of the sync link: bytes, FIFO fill level, UART states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "game_config.svh"

package link_pkg;

    // {left_clicked, game_starts, state[2:0], mode, 2'b00}
    typedef logic [7:0] sync_byte_t;

    // One bit wider than the pointers so a full FIFO is representable
    typedef logic [`GAME_FIFO_DEPTH_LOG2:0] fifo_count_t;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        START_BIT = 2'd1,
        DATA      = 2'd2,
        STOP_BIT  = 2'd3
    } tx_state_t;

endpackage

//--- verilog/round_judge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scores each shot and signals end of turn and end of match
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "game_config.svh"

module round_judge (
    input  logic             clk,
    input  logic             rst,
    input  logic             shot_done,
    input  logic             shot_goal,
    input  game_pkg::g_state game_state,
    output logic             end_gk,
    output logic             end_sh,
    output logic             match_end,
    output logic             match_result
);

    game_pkg::score_t player_score;
    game_pkg::score_t enemy_score;
    game_pkg::score_t round_cnt;
    game_pkg::score_t round_nxt;
    logic             in_keeper;
    logic             in_shooter;

    assign in_keeper  = (game_state == game_pkg::KEEPER);
    assign in_shooter = (game_state == game_pkg::SHOOTER);
    assign round_nxt  = round_cnt + game_pkg::score_t'(1);

    // Tie goes to the opponent
    assign match_result = (player_score > enemy_score);

    always_ff @(posedge clk) begin
        if (rst) begin
            player_score <= '0;
            enemy_score  <= '0;
            round_cnt    <= '0;
            end_gk       <= 1'b0;
            end_sh       <= 1'b0;
            match_end    <= 1'b0;
        end else begin
            end_gk    <= 1'b0;
            end_sh    <= 1'b0;
            match_end <= 1'b0;
            if (game_state == game_pkg::START) begin
                player_score <= '0;
                enemy_score  <= '0;
                round_cnt    <= '0;
            end else if (shot_done && (in_keeper || in_shooter)) begin
                if (shot_goal && in_keeper)
                    enemy_score <= enemy_score + game_pkg::score_t'(1);
                if (shot_goal && in_shooter)
                    player_score <= player_score + game_pkg::score_t'(1);
                round_cnt <= round_nxt;
                if (round_nxt == game_pkg::score_t'(`GAME_ROUNDS_PER_MATCH))
                    match_end <= 1'b1;
                else if (in_keeper)
                    end_gk <= 1'b1;
                else
                    end_sh <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/game_state_sel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game mode and state FSM, pushes a sync byte on every state change
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module game_state_sel (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 left_clicked,
    input  logic                 right_clicked,
    input  logic                 solo_enable,
    input  logic                 connect_corrected,
    input  logic                 enemy_shooter,
    input  logic                 game_starts,
    input  logic                 end_gk,
    input  logic                 end_sh,
    input  logic                 match_end,
    input  logic                 match_result,
    output game_pkg::g_state     game_state,
    output game_pkg::g_mode      game_mode,
    output logic                 push,
    output link_pkg::sync_byte_t push_data
);

    game_pkg::g_state game_state_nxt;
    game_pkg::g_mode  game_mode_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= game_pkg::START;
            game_mode  <= game_pkg::MULTI;
        end else begin
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
        end
    end

    // Mode is locked once a match is under way
    always_comb begin
        if (game_state == game_pkg::START) begin
            if (solo_enable)
                game_mode_nxt = game_pkg::SOLO;
            else
                game_mode_nxt = game_pkg::MULTI;
        end else begin
            game_mode_nxt = game_mode;
        end
    end

    always_comb begin
        game_state_nxt = game_state;
        case (game_state)
            game_pkg::START: begin
                if (game_mode == game_pkg::SOLO) begin
                    if (left_clicked)
                        game_state_nxt = game_pkg::KEEPER;
                end else if (game_starts) begin
                    if (enemy_shooter)
                        game_state_nxt = game_pkg::SHOOTER;
                    else
                        game_state_nxt = game_pkg::KEEPER;
                end
            end
            game_pkg::KEEPER: begin
                if (match_end) begin
                    if (match_result)
                        game_state_nxt = game_pkg::WINNER;
                    else
                        game_state_nxt = game_pkg::LOSER;
                end else if (end_gk) begin
                    game_state_nxt = game_pkg::SHOOTER;
                end
            end
            game_pkg::SHOOTER: begin
                if (match_end) begin
                    if (match_result)
                        game_state_nxt = game_pkg::WINNER;
                    else
                        game_state_nxt = game_pkg::LOSER;
                end else if (end_sh) begin
                    game_state_nxt = game_pkg::KEEPER;
                end
            end
            game_pkg::WINNER, game_pkg::LOSER: begin
                if (right_clicked)
                    game_state_nxt = game_pkg::START;
            end
            default: begin
                game_state_nxt = game_pkg::START;
            end
        endcase

        // Lost link aborts a multiplayer match
        if (game_mode == game_pkg::MULTI && !connect_corrected)
            game_state_nxt = game_pkg::START;
    end

    // Byte goes into the FIFO on the same edge that updates the state
    assign push      = (game_state_nxt != game_state);
    assign push_data = {left_clicked, game_starts, game_state_nxt, game_mode_nxt, 2'b00};

endmodule

//--- verilog/sync_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Show-ahead FIFO for sync bytes, drops writes when full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "game_config.svh"

module sync_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  link_pkg::sync_byte_t push_data,
    output logic                 pop_valid,
    output link_pkg::sync_byte_t pop_data,
    input  logic                 pop_ready,
    output logic                 overflow
);

    localparam int DEPTH = 1 << `GAME_FIFO_DEPTH_LOG2;

    link_pkg::sync_byte_t              mem [DEPTH];
    logic [`GAME_FIFO_DEPTH_LOG2-1:0]  wr_ptr;
    logic [`GAME_FIFO_DEPTH_LOG2-1:0]  rd_ptr;
    link_pkg::fifo_count_t             count;
    logic                              full;
    logic                              wr_en;
    logic                              rd_en;

    assign full      = (count == link_pkg::fifo_count_t'(DEPTH));
    assign wr_en     = push && !full;
    assign rd_en     = pop_valid && pop_ready;
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
            // Sticky until reset
            if (push && full)
                overflow <= 1'b1;
        end
    end

endmodule

//--- verilog/uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 UART transmitter, pulls bytes through a valid/ready handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "game_config.svh"

module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pop_valid,
    input  link_pkg::sync_byte_t pop_data,
    output logic                 pop_ready,
    output logic                 tx
);

    localparam int CNT_W = $clog2(`GAME_CLKS_PER_BIT + 1);

    link_pkg::tx_state_t  state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [2:0]           bit_idx;
    link_pkg::sync_byte_t shift_reg;
    logic                 bit_end;

    assign pop_ready = (state == link_pkg::IDLE);
    assign bit_end   = (bit_cnt == CNT_W'(`GAME_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= link_pkg::IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            if (state == link_pkg::IDLE || bit_end)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;
            case (state)
                link_pkg::IDLE: begin
                    if (pop_valid)
                        state <= link_pkg::START_BIT;
                end
                link_pkg::START_BIT: begin
                    if (bit_end) begin
                        state   <= link_pkg::DATA;
                        bit_idx <= '0;
                    end
                end
                link_pkg::DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= link_pkg::STOP_BIT;
                    end
                end
                link_pkg::STOP_BIT: begin
                    if (bit_end)
                        state <= link_pkg::IDLE;
                end
                default: state <= link_pkg::IDLE;
            endcase
        end
    end

    // LSB first, shifted out at the end of each data bit
    always_ff @(posedge clk) begin
        if (pop_valid && pop_ready)
            shift_reg <= pop_data;
        else if (state == link_pkg::DATA && bit_end)
            shift_reg <= shift_reg >> 1;
    end

    always_comb begin
        case (state)
            link_pkg::START_BIT: tx = 1'b0;
            link_pkg::DATA:      tx = shift_reg[0];
            default:             tx = 1'b1;
        endcase
    end

endmodule

//--- verilog/game_link_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Match controller top: judge, state FSM, sync FIFO and UART transmitter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module game_link_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             left_clicked,
    input  logic             right_clicked,
    input  logic             game_starts,
    input  logic             shot_done,
    input  logic             shot_goal,
    input  logic             solo_enable,
    input  logic             connect_corrected,
    input  logic             enemy_shooter,
    output game_pkg::g_state game_state,
    output game_pkg::g_mode  game_mode,
    output logic             tx,
    output logic             link_overflow
);

    logic                 end_gk;
    logic                 end_sh;
    logic                 match_end;
    logic                 match_result;
    logic                 push;
    link_pkg::sync_byte_t push_data;
    logic                 pop_valid;
    link_pkg::sync_byte_t pop_data;
    logic                 pop_ready;

    round_judge i_round_judge (
        .clk          (clk),
        .rst          (rst),
        .shot_done    (shot_done),
        .shot_goal    (shot_goal),
        .game_state   (game_state),
        .end_gk       (end_gk),
        .end_sh       (end_sh),
        .match_end    (match_end),
        .match_result (match_result)
    );

    game_state_sel i_game_state_sel (
        .clk               (clk),
        .rst               (rst),
        .left_clicked      (left_clicked),
        .right_clicked     (right_clicked),
        .solo_enable       (solo_enable),
        .connect_corrected (connect_corrected),
        .enemy_shooter     (enemy_shooter),
        .game_starts       (game_starts),
        .end_gk            (end_gk),
        .end_sh            (end_sh),
        .match_end         (match_end),
        .match_result      (match_result),
        .game_state        (game_state),
        .game_mode         (game_mode),
        .push              (push),
        .push_data         (push_data)
    );

    sync_fifo i_sync_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop_valid (pop_valid),
        .pop_data  (pop_data),
        .pop_ready (pop_ready),
        .overflow  (link_overflow)
    );

    uart_tx i_uart_tx (
        .clk       (clk),
        .rst       (rst),
        .pop_valid (pop_valid),
        .pop_data  (pop_data),
        .pop_ready (pop_ready),
        .tx        (tx)
    );

endmodule

//--- verif/game_link_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for game_link_top with a UART frame decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "game_config.svh"

module game_link_tb;

    localparam int CLKS       = `GAME_CLKS_PER_BIT;
    localparam int NROWS      = 17;
    localparam int RX_TIMEOUT = 2000;

    typedef enum logic [2:0] {PL_NONE, PL_LEFT, PL_RIGHT, PL_START, PL_SHOT} pulse_t;

    typedef struct packed {
        logic             solo;
        logic             conn;
        logic             enemy;
        pulse_t           pulse;
        logic             goal;
        logic             scored;
        logic [7:0]       idle;
        game_pkg::g_state exp_state;
        game_pkg::g_mode  exp_mode;
    } row_t;

    logic clk;
    logic rst;
    logic left_clicked;
    logic right_clicked;
    logic game_starts;
    logic shot_done;
    logic shot_goal;
    logic solo_enable;
    logic connect_corrected;
    logic enemy_shooter;
    game_pkg::g_state game_state;
    game_pkg::g_mode  game_mode;
    logic tx;
    logic link_overflow;

    row_t                 rows [NROWS];
    link_pkg::sync_byte_t exp_q[$];
    link_pkg::sync_byte_t rx_q[$];
    game_pkg::g_state     prev_state;
    int                   checks;
    int                   errors;

    game_link_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .left_clicked      (left_clicked),
        .right_clicked     (right_clicked),
        .game_starts       (game_starts),
        .shot_done         (shot_done),
        .shot_goal         (shot_goal),
        .solo_enable       (solo_enable),
        .connect_corrected (connect_corrected),
        .enemy_shooter     (enemy_shooter),
        .game_state        (game_state),
        .game_mode         (game_mode),
        .tx                (tx),
        .link_overflow     (link_overflow)
    );

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic link_pkg::sync_byte_t predict_byte(input pulse_t p,
            input game_pkg::g_state s, input game_pkg::g_mode m);
        return {p == PL_LEFT, p == PL_START, s, m, 2'b00};
    endfunction

    function automatic row_t make_row(input logic solo, input logic conn, input logic enemy,
            input pulse_t p, input logic [7:0] idle, input game_pkg::g_state s,
            input game_pkg::g_mode m, input logic scored);
        row_t r;
        r.solo      = solo;
        r.conn      = conn;
        r.enemy     = enemy;
        r.pulse     = p;
        r.goal      = 1'b0;
        r.scored    = scored;
        r.idle      = idle;
        r.exp_state = s;
        r.exp_mode  = m;
        return r;
    endfunction

    task automatic check_state(input game_pkg::g_state got, input game_pkg::g_state exp,
            input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s state %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_mode(input game_pkg::g_mode got, input game_pkg::g_mode exp,
            input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s mode %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input link_pkg::sync_byte_t got,
            input link_pkg::sync_byte_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: frame %0d byte %h, expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Goals come from the LFSR; the end-of-match row is scored from the same bits
    task automatic build_table();
        logic [31:0]      lfsr;
        game_pkg::g_state prev;
        int               player;
        int               enemy;
        rows[0]  = make_row(0, 0, 0, PL_START, 4, game_pkg::START, game_pkg::MULTI, 0);
        rows[1]  = make_row(1, 0, 0, PL_NONE, 4, game_pkg::START, game_pkg::SOLO, 0);
        rows[2]  = make_row(1, 0, 0, PL_LEFT, 44, game_pkg::KEEPER, game_pkg::SOLO, 0);
        rows[3]  = make_row(1, 0, 0, PL_SHOT, 44, game_pkg::SHOOTER, game_pkg::SOLO, 0);
        rows[4]  = make_row(0, 0, 0, PL_SHOT, 44, game_pkg::KEEPER, game_pkg::SOLO, 0);
        rows[5]  = make_row(0, 0, 0, PL_SHOT, 44, game_pkg::SHOOTER, game_pkg::SOLO, 0);
        rows[6]  = make_row(1, 0, 0, PL_SHOT, 44, game_pkg::KEEPER, game_pkg::SOLO, 0);
        rows[7]  = make_row(1, 0, 0, PL_SHOT, 44, game_pkg::SHOOTER, game_pkg::SOLO, 0);
        rows[8]  = make_row(1, 0, 0, PL_SHOT, 44, game_pkg::LOSER, game_pkg::SOLO, 1);
        rows[9]  = make_row(1, 0, 0, PL_RIGHT, 44, game_pkg::START, game_pkg::SOLO, 0);
        rows[10] = make_row(0, 1, 1, PL_NONE, 4, game_pkg::START, game_pkg::MULTI, 0);
        rows[11] = make_row(0, 1, 1, PL_START, 44, game_pkg::SHOOTER, game_pkg::MULTI, 0);
        rows[12] = make_row(0, 1, 1, PL_SHOT, 44, game_pkg::KEEPER, game_pkg::MULTI, 0);
        rows[13] = make_row(0, 0, 1, PL_NONE, 44, game_pkg::START, game_pkg::MULTI, 0);
        rows[14] = make_row(0, 1, 0, PL_START, 44, game_pkg::KEEPER, game_pkg::MULTI, 0);
        rows[15] = make_row(0, 0, 0, PL_NONE, 44, game_pkg::START, game_pkg::MULTI, 0);
        rows[16] = make_row(0, 1, 0, PL_NONE, 4, game_pkg::START, game_pkg::MULTI, 0);
        lfsr   = 32'ha774_d89d;
        prev   = game_pkg::START;
        player = 0;
        enemy  = 0;
        for (int i = 0; i < NROWS; i++) begin
            if (prev == game_pkg::START) begin
                player = 0;
                enemy  = 0;
            end
            if (rows[i].pulse == PL_SHOT) begin
                lfsr = lfsr_next(lfsr);
                rows[i].goal = lfsr[0];
                if (prev == game_pkg::KEEPER && rows[i].goal)
                    enemy++;
                if (prev == game_pkg::SHOOTER && rows[i].goal)
                    player++;
            end
            if (rows[i].scored)
                rows[i].exp_state = (player > enemy) ? game_pkg::WINNER : game_pkg::LOSER;
            prev = rows[i].exp_state;
        end
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   err_before;
        r = rows[idx];
        err_before = errors;
        @(posedge clk);
        solo_enable       <= r.solo;
        connect_corrected <= r.conn;
        enemy_shooter     <= r.enemy;
        left_clicked      <= (r.pulse == PL_LEFT);
        right_clicked     <= (r.pulse == PL_RIGHT);
        game_starts       <= (r.pulse == PL_START);
        shot_done         <= (r.pulse == PL_SHOT);
        shot_goal         <= r.goal;
        @(posedge clk);
        left_clicked  <= 1'b0;
        right_clicked <= 1'b0;
        game_starts   <= 1'b0;
        shot_done     <= 1'b0;
        shot_goal     <= 1'b0;
        repeat (r.idle) @(posedge clk);
        @(negedge clk);
        check_state(game_state, r.exp_state, $sformatf("row %0d", idx));
        check_mode(game_mode, r.exp_mode, $sformatf("row %0d", idx));
        if (r.exp_state != prev_state)
            exp_q.push_back(predict_byte(r.pulse, r.exp_state, r.exp_mode));
        prev_state = r.exp_state;
        if (errors == err_before)
            $display("row %0d passed: state %0d mode %0d", idx, game_state, game_mode);
        else
            $display("row %0d failed", idx);
    endtask

    // Samples each bit near its middle, on the falling edge
    initial begin : frame_decoder
        int                   waited;
        link_pkg::sync_byte_t data;
        forever begin
            waited = 0;
            while (tx !== 1'b0 && waited < RX_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (tx !== 1'b0) begin
                $display("No UART start bit seen within %0d cycles", RX_TIMEOUT);
                errors++;
            end else begin
                repeat (CLKS / 2) @(negedge clk);
                if (tx !== 1'b0) begin
                    $display("UART start bit did not stay low at %0t ns", $time);
                    errors++;
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS) @(negedge clk);
                    data[b] = tx;
                end
                repeat (CLKS) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("UART stop bit missing at %0t ns", $time);
                    errors++;
                end
                rx_q.push_back(data);
            end
        end
    end

    initial begin : main_seq
        int waited;
        clk               = 1'b0;
        rst               = 1'b1;
        left_clicked      = 1'b0;
        right_clicked     = 1'b0;
        game_starts       = 1'b0;
        shot_done         = 1'b0;
        shot_goal         = 1'b0;
        solo_enable       = 1'b0;
        connect_corrected = 1'b0;
        enemy_shooter     = 1'b0;
        checks            = 0;
        errors            = 0;
        prev_state        = game_pkg::START;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_state(game_state, game_pkg::START, "after reset");
        check_mode(game_mode, game_pkg::MULTI, "after reset");
        check_flag(tx, 1'b1, "tx after reset");
        check_flag(link_overflow, 1'b0, "link_overflow after reset");
        for (int i = 0; i < NROWS; i++)
            apply_row(i);
        waited = 0;
        while (rx_q.size() < exp_q.size() && waited < RX_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_q.size() < exp_q.size()) begin
            $display("Timed out waiting for UART frames, got %0d of %0d",
                     rx_q.size(), exp_q.size());
            errors++;
        end
        // Room for any extra frame to show up
        repeat (2 * 10 * CLKS) @(negedge clk);
        if (rx_q.size() != exp_q.size()) begin
            $display("Expected %0d UART frames but received %0d", exp_q.size(), rx_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++)
            check_byte(rx_q[i], exp_q[i], i);
        check_flag(link_overflow, 1'b0, "link_overflow at end");
        $display("%0d checks, %0d errors, %0d frames", checks, errors, rx_q.size());
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/game_pkg.sv
verilog/link_pkg.sv
verilog/round_judge.sv
verilog/game_state_sel.sv
verilog/sync_fifo.sv
verilog/uart_tx.sv
verilog/game_link_top.sv
verif/game_link_tb.sv
